/* all.f */
+incdir+hdl
hdl/fpga_pkg.sv
hdl/spi_slave.sv
hdl/reg_file.sv
hdl/drive_uart_tx.sv
hdl/servo_pwm.sv
hdl/fpga_top.sv
verif/tb_fpga_top.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wall -Wno-fatal
TOP      = tb_fpga_top
RTL_TOP  = fpga_top
FILELIST = all.f
RTL      = $(filter-out verif/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

lint:
	$(TOOL) --lint-only -Wall --top-module $(RTL_TOP) $(RTL)

clean:
	rm -rf obj_dir

/* verif/tb_fpga_top.sv */
/* Directed testbench for the motor-control top level over SPI, UART and PWM.
   UART checks assume free-running transmitters that keep a fixed frame phase. */
`timescale 1ns/1ns
`include "fpga_consts.svh"

module tb_fpga_top;

    localparam int     CLK_NS     = 10;
    localparam int     SPI_HALF   = 8;                          // Clocks per SPI half period
    localparam int     UART_FRAME = 11 * `BAUD_CYCLES;          // Start, 8 data, stop, idle
    localparam int     GAP_PHASE  = UART_FRAME - 2 * `BAUD_CYCLES + `BAUD_CYCLES / 2;
    localparam int     PWM_PERIOD = 256 * `PWM_PRESCALE;
    localparam int     SPI_FRAME  = (2 * `SPI_FRAME_BITS + 3) * SPI_HALF;
    localparam longint TIMEOUT_NS = longint'(60 * SPI_FRAME + 30 * PWM_PERIOD
                                             + 40 * UART_FRAME) * CLK_NS;

    logic                  clock;
    logic                  reset;
    logic                  spi_clock;
    logic                  cs_n;
    logic                  mosi;
    logic                  miso;
    logic [`NUM_DRIVE-1:0] sd_uart;
    logic [`NUM_SERVO-1:0] servo_pwm;
    logic [31:0]           rng_state;       // Xorshift state
    time                   last_start;      // Start bit of the last captured frame
    time                   frame_origin;    // Frame phase of the locked channel

    fpga_top fpga_top_i (
        .clock     (clock),
        .reset     (reset),
        .spi_clock (spi_clock),
        .cs_n      (cs_n),
        .mosi      (mosi),
        .miso      (miso),
        .sd_uart   (sd_uart),
        .servo_pwm (servo_pwm)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_NS / 2) clock = ~clock;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        abort_run();
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        abort_run();
    endtask

    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else report_mismatch(what, got, exp);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [7:0] next_byte();
        rng_state = xorshift32(rng_state);
        return rng_state[7:0];
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clock);
    endtask

    //////////////////////////////////////////////////
    // SPI host, mode 0, MSB first
    //////////////////////////////////////////////////
    task automatic spi_transfer(input logic [15:0] frame, input int nbits,
                                output logic [`DATA_W-1:0] rx);
        rx = '0;
        @(posedge clock);
        cs_n <= 1'b0;
        for (int i = 0; i < nbits; i++) begin
            mosi <= frame[15 - i];                              // Moves with the falling edge
            wait_cycles(SPI_HALF);
            spi_clock <= 1'b1;
            if (i >= 8) begin
                rx = {rx[`DATA_W-2:0], miso};                   // Data half only
            end
            wait_cycles(SPI_HALF);
            spi_clock <= 1'b0;
        end
        wait_cycles(SPI_HALF);
        cs_n <= 1'b1;                                           // Short count aborts here
        wait_cycles(SPI_HALF);
    endtask

    task automatic spi_write(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data);
        logic [`DATA_W-1:0] ignored;
        spi_transfer({2'b00, addr, data}, `SPI_FRAME_BITS, ignored);
    endtask

    task automatic spi_read(input logic [`ADDR_W-1:0] addr, output logic [`DATA_W-1:0] data);
        spi_transfer({2'b10, addr, 8'h00}, `SPI_FRAME_BITS, data);
    endtask

    //////////////////////////////////////////////////
    // UART and PWM monitors
    //////////////////////////////////////////////////
    // Call between frames so the next falling edge is a start bit
    task automatic uart_capture(input int ch, output logic [`DATA_W-1:0] data);
        while (sd_uart[ch] !== 1'b1) @(posedge clock);
        while (sd_uart[ch] !== 1'b0) @(posedge clock);
        last_start = $time;
        wait_cycles(`BAUD_CYCLES / 2 - 1);                      // Middle of start bit
        assert (sd_uart[ch] == 1'b0) else report_mismatch("start bit", sd_uart[ch], 0);
        for (int i = 0; i < `DATA_W; i++) begin
            wait_cycles(`BAUD_CYCLES);
            data[i] = sd_uart[ch];                              // LSB first
        end
        wait_cycles(`BAUD_CYCLES);
        assert (sd_uart[ch] == 1'b1) else report_mismatch("stop bit", sd_uart[ch], 1);
    endtask

    // A 0x00 frame has a single falling edge at its start bit
    task automatic uart_lock(input int ch);
        logic [`DATA_W-1:0] data;
        spi_write(`ADDR_W'(`DRIVE_BASE + ch), 8'h00);
        wait_cycles(2 * UART_FRAME);                            // Old frames flushed
        uart_capture(ch, data);
        expect_equal("parked frame", data, 0);
        frame_origin = last_start;
    endtask

    task automatic wait_frame_gap();
        int phase;
        phase = int'(($time - frame_origin) / CLK_NS) % UART_FRAME;
        if (phase < GAP_PHASE) begin
            wait_cycles(GAP_PHASE - phase);                     // Into the stop bit
        end
    endtask

    task automatic pwm_measure(input int ch, output int high);
        logic prev;
        int   waited;
        prev   = servo_pwm[ch];
        waited = 0;
        while (waited < PWM_PERIOD + 8) begin
            @(posedge clock);
            waited++;
            if (!prev && servo_pwm[ch]) begin
                break;                                          // Period starts here
            end
            prev = servo_pwm[ch];
        end
        high = 0;
        repeat (PWM_PERIOD) begin
            high += int'(servo_pwm[ch]);
            @(posedge clock);
        end
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////
    task automatic check_reset_state();
        logic [`DATA_W-1:0] data;
        for (int i = 0; i < PWM_PERIOD; i++) begin
            @(posedge clock);
            if (i < `BAUD_CYCLES - 1) begin
                expect_equal("sd_uart after reset", sd_uart, {`NUM_DRIVE{1'b1}});
            end
            expect_equal("servo_pwm after reset", servo_pwm, 0);
        end
        for (int a = 0; a < 8; a++) begin
            spi_read(`ADDR_W'(a), data);
            expect_equal($sformatf("reset value at 0x%0h", a), data, 0);
        end
    endtask

    task automatic check_readback();
        logic [`DATA_W-1:0] expected [8];
        logic [`DATA_W-1:0] data;
        for (int a = 0; a < 8; a++) begin
            expected[a] = next_byte();
            spi_write(`ADDR_W'(a), expected[a]);
        end
        for (int a = 0; a < 8; a++) begin
            spi_read(`ADDR_W'(a), data);
            expect_equal($sformatf("readback at 0x%0h", a), data, expected[a]);
        end
        spi_write(`ADDR_W'('h20), next_byte());                // Unmapped
        spi_read(`ADDR_W'('h20), data);
        expect_equal("unmapped readback", data, 0);
        for (int a = 0; a < 8; a++) begin
            spi_read(`ADDR_W'(a), data);
            expect_equal($sformatf("0x%0h after unmapped write", a), data, expected[a]);
        end
    endtask

    task automatic check_drive_uart();
        logic [`DATA_W-1:0] raw;
        logic               brake;
        logic               enable;
        logic               direction;
        logic [4:0]         speed;
        logic [`DATA_W-1:0] cmd;
        logic [`DATA_W-1:0] first;
        logic [`DATA_W-1:0] second;
        for (int ch = 0; ch < `NUM_DRIVE; ch++) begin
            uart_lock(ch);
            raw       = next_byte();
            brake     = raw[0];
            enable    = raw[1];
            direction = raw[2];
            raw       = next_byte();
            speed     = raw[4:0];
            cmd       = {brake, enable, direction, speed};     // Motor protocol order
            spi_write(`ADDR_W'(`DRIVE_BASE + ch), cmd);
            wait_frame_gap();
            uart_capture(ch, first);
            uart_capture(ch, second);
            assert (first == 8'h00 || first == cmd) else report_mismatch("first frame", first, cmd);
            expect_equal($sformatf("ch%0d brake", ch), second[7], brake);
            expect_equal($sformatf("ch%0d enable", ch), second[6], enable);
            expect_equal($sformatf("ch%0d direction", ch), second[5], direction);
            expect_equal($sformatf("ch%0d speed", ch), second[4:0], speed);
        end
    endtask

    task automatic check_servo_pwm();
        logic [`DATA_W-1:0] positions [5];
        int                 ch;
        int                 high;
        positions    = '{8'd0, 8'd1, 8'd128, 8'd255, 8'd0};
        positions[4] = next_byte();
        for (int i = 0; i < 5; i++) begin
            ch = i % `NUM_SERVO;
            spi_write(`ADDR_W'(`SERVO_BASE + ch), positions[i]);
            wait_cycles(2 * PWM_PERIOD);                        // Latched at a wrap
            pwm_measure(ch, high);
            expect_equal($sformatf("servo %0d high time", ch), high,
                         int'(positions[i]) * `PWM_PRESCALE);
        end
    endtask

    task automatic check_aborted_frame();
        logic [`DATA_W-1:0] keep;
        logic [`DATA_W-1:0] data;
        keep = next_byte();
        spi_write(`ADDR_W'(`SERVO_BASE + 1), keep);
        spi_transfer({2'b00, `ADDR_W'(`SERVO_BASE + 1), ~keep}, 10, data);  // cs_n rises early
        spi_read(`ADDR_W'(`SERVO_BASE + 1), data);
        expect_equal("register after aborted frame", data, keep);
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        reset     = 1'b1;
        spi_clock = 1'b0;
        cs_n      = 1'b1;
        mosi      = 1'b0;
        rng_state = 32'hf67f_18ab;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        check_reset_state();
        check_readback();
        check_drive_uart();
        check_servo_pwm();
        check_aborted_frame();
        $display("Testbench passed");
        $finish;
    end

endmodule

/* hdl/fpga_top.sv */
/* Motor-control subsystem: SPI register access, four drive UARTs, four servo PWMs.
   Single clock domain; SPI pins are sampled by spi_slave. */
`timescale 1ns/1ns
`include "fpga_consts.svh"

module fpga_top (
    input  logic                  clock,       // System clock
    input  logic                  reset,       // Sync reset, active high
    input  logic                  spi_clock,   // SPI clock from host
    input  logic                  cs_n,        // Active low chip select
    input  logic                  mosi,        // Host to slave data
    output logic                  miso,        // Slave to host data
    output logic [`NUM_DRIVE-1:0] sd_uart,     // Drive motor UART lines
    output logic [`NUM_SERVO-1:0] servo_pwm    // Arm servo PWM lines
);

    logic [`ADDR_W-1:0]   address;                  // Register address
    logic                 write_en;                 // Write strobe
    logic [`DATA_W-1:0]   wr_data;                  // Write data
    logic                 read_en;                  // Read strobe
    logic [`DATA_W-1:0]   rd_data;                  // Readback
    fpga_pkg::drive_cmd_t drive_cmd [`NUM_DRIVE];   // {brake, enable, direction, speed}
    logic [`DATA_W-1:0]   servo_pos [`NUM_SERVO];   // Servo positions

    //////////////////////////////////////////////////
    // Host access
    //////////////////////////////////////////////////
    spi_slave spi_slave_i (
        .clock     (clock),
        .reset     (reset),
        .spi_clock (spi_clock),
        .cs_n      (cs_n),
        .mosi      (mosi),
        .rd_data   (rd_data),
        .miso      (miso),
        .address   (address),
        .write_en  (write_en),
        .wr_data   (wr_data),
        .read_en   (read_en)
    );

    reg_file reg_file_i (
        .clock     (clock),
        .reset     (reset),
        .address   (address),
        .write_en  (write_en),
        .wr_data   (wr_data),
        .read_en   (read_en),
        .rd_data   (rd_data),
        .drive_cmd (drive_cmd),
        .servo_pos (servo_pos)
    );

    //////////////////////////////////////////////////
    // Drive motors, one UART each
    //////////////////////////////////////////////////
    for (genvar g = 0; g < `NUM_DRIVE; g++) begin : g_drive
        drive_uart_tx drive_uart_tx_i (
            .clock   (clock),
            .reset   (reset),
            .cmd     (drive_cmd[g]),    // Brake and enable go out as bits 7 and 6
            .uart_tx (sd_uart[g])
        );
    end

    //////////////////////////////////////////////////
    // Arm servos
    //////////////////////////////////////////////////
    servo_pwm servo_pwm_i (
        .clock     (clock),
        .reset     (reset),
        .servo_pos (servo_pos),
        .servo_pwm (servo_pwm)
    );

endmodule

/* hdl/servo_pwm.sv */
/* Four servo PWM outputs on one 256-tick period of PWM_PRESCALE clocks per tick.
   Positions update only at the period boundary; outputs lag the counter by one clock. */
`timescale 1ns/1ns
`include "fpga_consts.svh"

module servo_pwm (
    input  logic               clock,                  // System clock
    input  logic               reset,                  // Sync reset, active high
    input  logic [`DATA_W-1:0] servo_pos [`NUM_SERVO], // Requested positions
    output logic [`NUM_SERVO-1:0] servo_pwm            // PWM outputs
);

    logic [$clog2(`PWM_PRESCALE)-1:0] pre_cnt;         // Prescaler
    logic [`DATA_W-1:0]               tick_cnt;        // Shared period counter
    logic [`DATA_W-1:0]               pos_q [`NUM_SERVO]; // Positions for this period
    logic                             tick;            // Counter advances
    logic                             wrap;            // Counter returns to 0

    assign tick = (pre_cnt == $bits(pre_cnt)'(`PWM_PRESCALE - 1));
    assign wrap = tick && (tick_cnt == '1);

    always_ff @(posedge clock) begin
        if (reset) begin
            pre_cnt   <= '0;
            tick_cnt  <= '0;
            servo_pwm <= '0;
            for (int i = 0; i < `NUM_SERVO; i++) begin
                pos_q[i] <= '0;
            end
        end else begin
            pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
            if (tick) begin
                tick_cnt <= tick_cnt + 1'b1;           // Wraps at 256
            end
            for (int i = 0; i < `NUM_SERVO; i++) begin
                if (wrap) begin
                    pos_q[i] <= servo_pos[i];          // Glitch-free update
                end
                servo_pwm[i] <= (tick_cnt < pos_q[i]); // High for pos ticks
            end
        end
    end

    // Zero position means no pulse at all
    for (genvar g = 0; g < `NUM_SERVO; g++) begin : g_chk
        a_zero_low: assert property (@(posedge clock) disable iff (reset)
            (pos_q[g] == '0) |-> !servo_pwm[g]);
    end

endmodule

/* hdl/drive_uart_tx.sv */
/* 8N1 transmitter that resends the drive command forever, one idle bit between frames.
   The command is sampled at each start bit, so a change shows up within two frames. */
`timescale 1ns/1ns
`include "fpga_consts.svh"

module drive_uart_tx (
    input  logic                 clock,     // System clock
    input  logic                 reset,     // Sync reset, active high
    input  fpga_pkg::drive_cmd_t cmd,       // Command to send
    output logic                 uart_tx    // Serial line, idle high
);

    localparam logic [1:0] ST_IDLE  = 2'd0;    // One idle bit
    localparam logic [1:0] ST_START = 2'd1;
    localparam logic [1:0] ST_DATA  = 2'd2;
    localparam logic [1:0] ST_STOP  = 2'd3;

    logic [1:0]                       state;
    logic [$clog2(`BAUD_CYCLES)-1:0]  baud_cnt;    // Cycles within a bit
    logic [$clog2(`DATA_W)-1:0]       bit_idx;     // Data bit being sent
    logic [`DATA_W-1:0]               tx_byte;     // Frame payload
    logic                             baud_tick;   // Last cycle of a bit

    assign baud_tick = (baud_cnt == $bits(baud_cnt)'(`BAUD_CYCLES - 1));

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= ST_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            uart_tx  <= 1'b1;
        end else if (!baud_tick) begin
            baud_cnt <= baud_cnt + 1'b1;
        end else begin
            baud_cnt <= '0;
            case (state)
                ST_IDLE: begin
                    state   <= ST_START;
                    uart_tx <= 1'b0;                           // Start bit
                    tx_byte <= {cmd.motor.brake, cmd.motor.enable,
                                cmd.motor.direction, cmd.motor.speed};
                end
                ST_START: begin
                    state   <= ST_DATA;
                    bit_idx <= '0;
                    uart_tx <= tx_byte[0];                     // LSB first
                end
                ST_DATA: begin
                    if (bit_idx == $bits(bit_idx)'(`DATA_W - 1)) begin
                        state   <= ST_STOP;
                        uart_tx <= 1'b1;                       // Stop bit
                    end else begin
                        bit_idx <= bit_idx + 1'b1;
                        uart_tx <= tx_byte[bit_idx + 1'b1];
                    end
                end
                default: begin
                    state   <= ST_IDLE;                        // Gap before next frame
                    uart_tx <= 1'b1;
                end
            endcase
        end
    end

    // Line is never low outside start and data bits
    a_idle_high: assert property (@(posedge clock) disable iff (reset)
        (state == ST_STOP || state == ST_IDLE) |-> uart_tx);

endmodule

/* hdl/reg_file.sv */
/* Drive and servo registers, one byte each, all visible on output ports.
   Unmapped addresses read as 0 and drop writes; readback is registered. */
`timescale 1ns/1ns
`include "fpga_consts.svh"

module reg_file (
    input  logic                 clock,                     // System clock
    input  logic                 reset,                     // Sync reset, active high
    input  logic [`ADDR_W-1:0]   address,                   // Register address
    input  logic                 write_en,                  // Write strobe
    input  logic [`DATA_W-1:0]   wr_data,                   // Write data
    input  logic                 read_en,                   // Read strobe
    output logic [`DATA_W-1:0]   rd_data,                   // Readback, valid after read_en
    output fpga_pkg::drive_cmd_t drive_cmd [`NUM_DRIVE],    // Drive commands
    output logic [`DATA_W-1:0]   servo_pos [`NUM_SERVO]     // Servo positions
);

    logic [`DATA_W-1:0] rd_next;                            // Decoded readback

    //////////////////////////////////////////////////
    // Read decode
    //////////////////////////////////////////////////
    always_comb begin
        rd_next = '0;                                       // Unmapped reads 0
        for (int i = 0; i < `NUM_DRIVE; i++) begin
            if (address == `ADDR_W'(`DRIVE_BASE + i)) begin
                rd_next = drive_cmd[i].raw;
            end
        end
        for (int i = 0; i < `NUM_SERVO; i++) begin
            if (address == `ADDR_W'(`SERVO_BASE + i)) begin
                rd_next = servo_pos[i];
            end
        end
    end

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            rd_data <= '0;
            for (int i = 0; i < `NUM_DRIVE; i++) begin
                drive_cmd[i].raw <= '0;                     // Motors stopped
            end
            for (int i = 0; i < `NUM_SERVO; i++) begin
                servo_pos[i] <= '0;                         // No servo pulse
            end
        end else begin
            if (read_en) begin
                rd_data <= rd_next;
            end
            if (write_en) begin
                for (int i = 0; i < `NUM_DRIVE; i++) begin
                    if (address == `ADDR_W'(`DRIVE_BASE + i)) begin
                        drive_cmd[i].raw <= wr_data;        // Stored as raw byte
                    end
                end
                for (int i = 0; i < `NUM_SERVO; i++) begin
                    if (address == `ADDR_W'(`SERVO_BASE + i)) begin
                        servo_pos[i] <= wr_data;
                    end
                end
            end
        end
    end

    // Strobed address must be driven, checks the SPI side too
    a_addr_known: assert property (@(posedge clock) disable iff (reset)
        (write_en || read_en) |-> !$isunknown(address));

endmodule

/* hdl/spi_slave.sv */
/* Mode-0 SPI slave, 16-bit frames: op, ignored bit, 6-bit address, 8-bit data.
   Pins are oversampled by the system clock; spi_clock half period must be >= 6 clocks. */
`timescale 1ns/1ns
`include "fpga_consts.svh"

module spi_slave (
    input  logic               clock,      // System clock
    input  logic               reset,      // Sync reset, active high
    input  logic               spi_clock,  // SPI clock from host
    input  logic               cs_n,       // Active low chip select
    input  logic               mosi,       // Host to slave data
    input  logic [`DATA_W-1:0] rd_data,    // Readback from register file
    output logic               miso,       // Slave to host data
    output logic [`ADDR_W-1:0] address,    // Register address
    output logic               write_en,   // One-cycle write strobe
    output logic [`DATA_W-1:0] wr_data,    // Write data
    output logic               read_en     // One-cycle read strobe
);

    logic [2:0]                            sclk_sync;  // Two sync stages plus edge history
    logic [1:0]                            cs_sync;    // Chip select synchronizer
    logic [1:0]                            mosi_sync;  // Data synchronizer
    logic                                  sclk_rise;  // Rising SPI edge seen
    logic                                  sclk_fall;  // Falling SPI edge seen
    logic                                  cs_active;  // Frame in progress
    logic [$clog2(`SPI_FRAME_BITS):0]      bit_cnt;    // Bits received, up to 16
    logic [`SPI_FRAME_BITS-2:0]            shift_in;   // Bits received so far
    logic [`DATA_W-1:0]                    shift_out;  // Read data going out
    logic                                  read_en_q;  // rd_data valid this cycle

    assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
    assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
    assign cs_active = ~cs_sync[1];

    //////////////////////////////////////////////////
    // Pin synchronizers
    //////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            sclk_sync <= '0;
            cs_sync   <= 2'b11;                        // Deselected
            mosi_sync <= '0;
        end else begin
            sclk_sync <= {sclk_sync[1:0], spi_clock};
            cs_sync   <= {cs_sync[0], cs_n};
            mosi_sync <= {mosi_sync[0], mosi};
        end
    end

    //////////////////////////////////////////////////
    // Receive side and register strobes
    //////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            bit_cnt   <= '0;
            shift_in  <= '0;
            address   <= '0;
            wr_data   <= '0;
            write_en  <= 1'b0;
            read_en   <= 1'b0;
        end else begin
            write_en <= 1'b0;                          // Strobes last one cycle
            read_en  <= 1'b0;
            if (!cs_active) begin
                bit_cnt <= '0;                         // Short frame drops here
            end else if (sclk_rise && bit_cnt != `SPI_FRAME_BITS) begin
                shift_in <= {shift_in[`SPI_FRAME_BITS-3:0], mosi_sync[1]};
                bit_cnt  <= bit_cnt + 1'b1;
                if (bit_cnt == 7) begin                // Address byte complete
                    address <= {shift_in[4:0], mosi_sync[1]};
                    read_en <= shift_in[6];            // Op bit 1 = read
                end
                if (bit_cnt == `SPI_FRAME_BITS - 1 && !shift_in[14]) begin
                    wr_data  <= {shift_in[6:0], mosi_sync[1]};
                    write_en <= 1'b1;                  // Full write frame
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Transmit side
    //////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            read_en_q <= 1'b0;
            shift_out <= '0;
            miso      <= 1'b0;
        end else begin
            read_en_q <= read_en;
            if (!cs_active) begin
                shift_out <= '0;
                miso      <= 1'b0;
            end else if (read_en_q) begin
                shift_out <= rd_data;                  // Before the 8th falling edge
            end else if (sclk_fall) begin
                miso      <= shift_out[`DATA_W-1];     // MSB first
                shift_out <= {shift_out[`DATA_W-2:0], 1'b0};
            end
        end
    end

    // Op bit selects exactly one strobe per frame
    a_one_strobe: assert property (@(posedge clock) disable iff (reset)
        !(write_en && read_en));

endmodule

/* hdl/fpga_pkg.sv */
/* Drive command byte with a raw view and a motor-field view.
   Field order is fixed by the motor controller's UART protocol. */
`include "fpga_consts.svh"

package fpga_pkg;

    //////////////////////////////////////////////////
    // Drive command
    //////////////////////////////////////////////////
    typedef union packed {
        logic [`DATA_W-1:0] raw;        // Byte as stored in the register file
        struct packed {
            logic       brake;          // Motor brake, MSB
            logic       enable;         // Motor enable
            logic       direction;      // Spin direction
            logic [4:0] speed;          // Speed magnitude
        } motor;                        // Field view for the transmitter
    } drive_cmd_t;

endpackage

/* hdl/fpga_consts.svh */
/* Sizes, register map and timing for the motor-control subsystem.
   BAUD_CYCLES and PWM_PRESCALE are in system clock cycles; changing them retimes both outputs. */
`ifndef FPGA_CONSTS_SVH
`define FPGA_CONSTS_SVH

// Register bus
`define DATA_W          8       // Register data width
`define ADDR_W          6       // Register address width

// Register map
`define NUM_DRIVE       4       // Drive UART channels
`define NUM_SERVO       4       // Servo PWM channels
`define DRIVE_BASE      6'h00   // Drive n at DRIVE_BASE + n
`define SERVO_BASE      6'h04   // Servo n at SERVO_BASE + n

// Timing
`define BAUD_CYCLES     16      // Clocks per UART bit
`define PWM_PRESCALE    4       // Clocks per PWM tick, 256 ticks per period
`define SPI_FRAME_BITS  16      // Bits per SPI frame

`endif
